//--- hw/fetch_cfg.svh
`ifndef FETCH_CFG_SVH
`define FETCH_CFG_SVH

// Number of cache lines the fetch queue can hold.
`define FETCH_Q_LINES 4

// Direct-mapped instruction cache size in lines.
`define FETCH_IC_LINES 8

// Backing line memory size in lines, and its read latency in cycles.
`define FETCH_MEM_LINES 64
`define FETCH_MEM_LATENCY 2

`endif

//--- hw/fetch_pkg.sv
package fetch_pkg;

   // Byte address and a single instruction word.
   typedef logic [31:0] addr_t;
   typedef logic [31:0] inst_t;

   // Four instructions per line. Word k sits in bits 32k+31 down to 32k.
   typedef logic [127:0] line_t;

   // Line address is the byte address without its low four bits.
   typedef logic [27:0] line_addr_t;
   typedef logic [5:0]  mem_idx_t;

   typedef struct packed {
      logic       valid;
      line_addr_t addr;
   } fetch_req_t;

   typedef struct packed {
      logic  valid;
      line_t line;
   } fetch_rsp_t;

   typedef struct packed {
      logic     valid;
      mem_idx_t idx;
   } mem_req_t;

   typedef struct packed {
      logic  valid;
      line_t line;
   } mem_rsp_t;

   typedef struct packed {
      logic     valid;
      mem_idx_t idx;
      line_t    line;
   } load_t;

   typedef enum logic [1:0] {ic_idle, ic_hit, ic_refill, ic_drop} ic_state_t;

endpackage

//--- hw/fetch_top.sv
`timescale 1ns/1ps

module fetch_top (
   input  logic             clk,
   input  logic             rst,
   input  fetch_pkg::load_t load,
   input  logic             dispatch_ren,
   input  logic             branch_valid,
   input  fetch_pkg::addr_t branch_addr,
   output fetch_pkg::inst_t dispatch_inst,
   output fetch_pkg::addr_t dispatch_pc_plus4,
   output logic             dispatch_empty
);
   import fetch_pkg::*;

   // Memory side of the cache.
   mem_req_t   mem_req;
   mem_rsp_t   mem_rsp;
   logic       mem_gnt;

   // Fetch queue side of the cache.
   fetch_req_t fetch_req;
   fetch_rsp_t fetch_rsp;
   logic       icache_ready;
   logic       icache_abort;

   line_mem line_mem_inst (
      .clk     (clk),
      .rst     (rst),
      .load    (load),
      .mem_req (mem_req),
      .mem_gnt (mem_gnt),
      .mem_rsp (mem_rsp)
   );

   icache icache_inst (
      .clk          (clk),
      .rst          (rst),
      .fetch_req    (fetch_req),
      .icache_ready (icache_ready),
      .icache_abort (icache_abort),
      .fetch_rsp    (fetch_rsp),
      .mem_req      (mem_req),
      .mem_gnt      (mem_gnt),
      .mem_rsp      (mem_rsp)
   );

   ifq ifq_inst (
      .clk               (clk),
      .rst               (rst),
      .fetch_req         (fetch_req),
      .icache_ready      (icache_ready),
      .icache_abort      (icache_abort),
      .fetch_rsp         (fetch_rsp),
      .dispatch_ren      (dispatch_ren),
      .branch_valid      (branch_valid),
      .branch_addr       (branch_addr),
      .dispatch_inst     (dispatch_inst),
      .dispatch_pc_plus4 (dispatch_pc_plus4),
      .dispatch_empty    (dispatch_empty)
   );

endmodule

//--- hw/icache.sv
`timescale 1ns/1ps
`include "fetch_cfg.svh"

module icache (
   input  logic                  clk,
   input  logic                  rst,
   input  fetch_pkg::fetch_req_t fetch_req,
   output logic                  icache_ready,
   input  logic                  icache_abort,
   output fetch_pkg::fetch_rsp_t fetch_rsp,
   output fetch_pkg::mem_req_t   mem_req,
   input  logic                  mem_gnt,
   input  fetch_pkg::mem_rsp_t   mem_rsp
);
   import fetch_pkg::*;

   localparam int IDX_W = $clog2(`FETCH_IC_LINES);
   localparam int TAG_W = $bits(line_addr_t) - IDX_W;

   line_t                data_q [`FETCH_IC_LINES];
   logic [TAG_W-1:0]     tag_q  [`FETCH_IC_LINES];
   logic [`FETCH_IC_LINES-1:0] valid_q;

   ic_state_t        state;
   ic_state_t        state_next;
   line_addr_t       req_addr;
   logic             mem_sent;
   logic [IDX_W-1:0] lk_idx;
   logic [TAG_W-1:0] lk_tag;
   logic [IDX_W-1:0] req_idx;
   logic [TAG_W-1:0] req_tag;
   logic             lk_hit;
   logic             accept;
   logic             in_refill;
   logic             refill_done;

   // Tag lookup on the incoming request address.
   assign lk_idx = fetch_req.addr[IDX_W-1:0];
   assign lk_tag = fetch_req.addr[$bits(line_addr_t)-1:IDX_W];
   assign lk_hit = valid_q[lk_idx] && (tag_q[lk_idx] == lk_tag);

   assign req_idx = req_addr[IDX_W-1:0];
   assign req_tag = req_addr[$bits(line_addr_t)-1:IDX_W];

   assign icache_ready = (state == ic_idle);
   assign accept       = fetch_req.valid && icache_ready;
   assign in_refill    = (state == ic_refill) || (state == ic_drop);
   assign refill_done  = in_refill && mem_rsp.valid;

   // The read request stays up until line_mem grants it.
   assign mem_req.valid = in_refill && !mem_sent;
   assign mem_req.idx   = req_addr[$bits(mem_idx_t)-1:0];

   // An abort in the response cycle kills the response as well.
   assign fetch_rsp.valid = (state == ic_hit) && !icache_abort;
   assign fetch_rsp.line  = data_q[req_idx];

   always_comb begin
      state_next = state;
      case (state)
         ic_idle: begin
            if (accept) begin
               state_next = lk_hit ? ic_hit : ic_refill;
            end
         end
         ic_hit: begin
            state_next = ic_idle;
         end
         ic_refill: begin
            if (icache_abort) begin
               state_next = mem_rsp.valid ? ic_idle : ic_drop;
            end else if (mem_rsp.valid) begin
               state_next = ic_hit;
            end
         end
         ic_drop: begin
            if (mem_rsp.valid) begin
               state_next = ic_idle;
            end
         end
         default: begin
            state_next = ic_idle;
         end
      endcase
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         state    <= ic_idle;
         mem_sent <= 1'b0;
         valid_q  <= '0;
      end else begin
         state <= state_next;
         if (mem_req.valid && mem_gnt) begin
            mem_sent <= 1'b1;
         end else if (refill_done) begin
            mem_sent <= 1'b0;
         end
         if (refill_done) begin
            valid_q[req_idx] <= 1'b1;
         end
      end
   end

   // Aborted refills still fill their line.
   always_ff @(posedge clk) begin
      if (accept) begin
         req_addr <= fetch_req.addr;
      end
      if (refill_done) begin
         data_q[req_idx] <= mem_rsp.line;
         tag_q[req_idx]  <= req_tag;
      end
   end

   a_no_rsp_idle_drop: assert property (@(posedge clk) disable iff (rst)
      (state == ic_idle || state == ic_drop) |-> !fetch_rsp.valid);

   // Aborts only come while a request is being served.
   a_abort_in_flight: assert property (@(posedge clk) disable iff (rst)
      icache_abort |-> (state == ic_hit || state == ic_refill));

endmodule

//--- hw/ifq.sv
`timescale 1ns/1ps
`include "fetch_cfg.svh"

module ifq (
   input  logic                  clk,
   input  logic                  rst,
   output fetch_pkg::fetch_req_t fetch_req,
   input  logic                  icache_ready,
   output logic                  icache_abort,
   input  fetch_pkg::fetch_rsp_t fetch_rsp,
   input  logic                  dispatch_ren,
   input  logic                  branch_valid,
   input  fetch_pkg::addr_t      branch_addr,
   output fetch_pkg::inst_t      dispatch_inst,
   output fetch_pkg::addr_t      dispatch_pc_plus4,
   output logic                  dispatch_empty
);
   import fetch_pkg::*;

   localparam int QI = $clog2(`FETCH_Q_LINES);
   localparam logic [QI:0] Q_LINES = `FETCH_Q_LINES;

   // Write pointer counts lines. The read pointer counts words, so its low two
   // bits are the word offset inside the head line.
   line_t         q_line [`FETCH_Q_LINES];
   logic [QI:0]   wptr;
   logic [QI+2:0] rptr;
   logic [QI:0]   q_count;
   logic          q_empty;
   line_t         head_line;

   line_addr_t fetch_line;
   addr_t      head_pc;
   logic       started;
   logic       outstanding;
   logic       req_acc;
   logic       rsp_take;
   logic       pop;

   function automatic inst_t pick_word(line_t l, logic [1:0] k);
      return l[32*k +: 32];
   endfunction

   assign q_count = wptr - rptr[QI+2:2];
   assign q_empty = (q_count == '0);

   // A response landing in a branch cycle belongs to the old stream.
   assign rsp_take = fetch_rsp.valid && !branch_valid;

   // With nothing queued the arriving line goes straight to dispatch.
   assign head_line         = q_empty ? fetch_rsp.line : q_line[rptr[QI+1:2]];
   assign dispatch_inst     = pick_word(head_line, rptr[1:0]);
   assign dispatch_empty    = q_empty && !rsp_take;
   assign dispatch_pc_plus4 = head_pc + 32'd4;
   assign pop               = dispatch_ren && !dispatch_empty;

   // One request at a time, and only while its line is sure to fit.
   assign fetch_req.valid = started && !outstanding && icache_ready && !branch_valid &&
                            (q_count < Q_LINES);
   assign fetch_req.addr  = fetch_line;
   assign req_acc         = fetch_req.valid && icache_ready;

   // A branch kills whatever line the cache is still working on.
   assign icache_abort = branch_valid && outstanding;

   always_ff @(posedge clk) begin
      if (rst) begin
         wptr        <= '0;
         rptr        <= '0;
         started     <= 1'b0;
         outstanding <= 1'b0;
         fetch_line  <= '0;
         head_pc     <= '0;
      end else if (branch_valid) begin
         // Flush, then restart at the target line and word.
         wptr        <= '0;
         rptr        <= {{(QI+1){1'b0}}, branch_addr[3:2]};
         started     <= 1'b1;
         outstanding <= 1'b0;
         fetch_line  <= branch_addr[31:4];
         head_pc     <= {branch_addr[31:2], 2'b00};
      end else begin
         if (rsp_take) begin
            wptr <= wptr + 1'b1;
         end
         if (pop) begin
            rptr    <= rptr + 1'b1;
            head_pc <= head_pc + 32'd4;
         end
         if (req_acc) begin
            outstanding <= 1'b1;
            fetch_line  <= fetch_line + 1'b1;
         end else if (fetch_rsp.valid) begin
            outstanding <= 1'b0;
         end
      end
   end

   // Lines are written even when bypassed, since the rest of the line
   // is read from the queue afterwards.
   always_ff @(posedge clk) begin
      if (rsp_take) begin
         q_line[wptr[QI-1:0]] <= fetch_rsp.line;
      end
   end

   a_occupancy: assert property (@(posedge clk) disable iff (rst)
      q_count <= Q_LINES);

   a_rsp_outstanding: assert property (@(posedge clk) disable iff (rst)
      fetch_rsp.valid |-> outstanding);

endmodule

//--- hw/line_mem.sv
`timescale 1ns/1ps
`include "fetch_cfg.svh"

module line_mem (
   input  logic                clk,
   input  logic                rst,
   input  fetch_pkg::load_t    load,
   input  fetch_pkg::mem_req_t mem_req,
   output logic                mem_gnt,
   output fetch_pkg::mem_rsp_t mem_rsp
);
   import fetch_pkg::*;

   localparam int CNT_W = $clog2(`FETCH_MEM_LATENCY + 1);
   localparam logic [CNT_W-1:0] LAT = `FETCH_MEM_LATENCY;
   localparam logic [CNT_W-1:0] LAST = 1;

   line_t            mem_q [`FETCH_MEM_LINES];
   line_t            rd_line;
   logic [CNT_W-1:0] lat_cnt;
   logic             accept;

   // The loader has priority, so a refill read is only granted when no load is
   // pending and the previous read has come back.
   assign mem_gnt = (lat_cnt == '0) && !load.valid;
   assign accept  = mem_req.valid && mem_gnt;

   // The counter reaches one in the last cycle of the read.
   assign mem_rsp.valid = (lat_cnt == LAST);
   assign mem_rsp.line  = rd_line;

   always_ff @(posedge clk) begin
      if (rst) begin
         lat_cnt <= '0;
      end else if (accept) begin
         lat_cnt <= LAT;
      end else if (lat_cnt != '0) begin
         lat_cnt <= lat_cnt - 1'b1;
      end
   end

   // The line is captured at acceptance and held until it is returned.
   always_ff @(posedge clk) begin
      if (load.valid) begin
         mem_q[load.idx] <= load.line;
      end
      if (accept) begin
         rd_line <= mem_q[mem_req.idx];
      end
   end

   a_one_read: assert property (@(posedge clk) disable iff (rst)
      accept |=> !accept [*`FETCH_MEM_LATENCY]);

   // A refill read that is not granted stays up for the same line.
   a_req_held: assert property (@(posedge clk) disable iff (rst)
      mem_req.valid && !mem_gnt |=> mem_req.valid && $stable(mem_req.idx));

endmodule

//--- verif/fetch_tests.svh
`ifndef FETCH_TESTS_SVH
`define FETCH_TESTS_SVH

// Nothing may be fetched before the first redirect.
task automatic idle_before_branch();
   int err_before;
   err_before = errors;
   repeat (20) begin
      @(negedge clk);
      check_val("dispatch_empty", 1, dispatch_empty);
   end
   @(posedge clk);
   #1;
   report_test("idle_before_branch", err_before);
endtask

task automatic load_program();
   for (int i = 0; i < `FETCH_MEM_LINES; i++) begin
      load.valid = 1'b1;
      load.idx   = mem_idx_t'(i);
      load.line  = model_line(i);
      @(posedge clk);
      #1;
   end
   load = '0;
endtask

// Cold start from address 0 with dispatch popping as fast as it can.
task automatic sequential_fetch();
   int    err_before;
   addr_t pc;
   err_before = errors;
   issue_branch(32'h0);
   pc = 32'h0;
   repeat (40) begin
      pop_expect(pc);
      pc = pc + 32'd4;
   end
   report_test("sequential_fetch", err_before);
endtask

task automatic backpressure_fetch();
   int    err_before;
   int    n;
   addr_t pc;
   err_before = errors;
   issue_branch(32'h100);
   // With no pops the queue fills and the fetch requests stop.
   wait_queue_full();
   repeat (8) begin
      @(posedge clk);
      #1;
      check_val("fetch_req.valid", 0, fetch_top_inst.fetch_req.valid);
   end
   pc = 32'h100;
   n  = 0;
   while (n < 32) begin
      if ($urandom % 4 == 0) begin
         pop_expect(pc);
         pc = pc + 32'd4;
         n++;
      end else begin
         @(posedge clk);
         #1;
      end
   end
   report_test("backpressure_fetch", err_before);
endtask

task automatic branch_during_refill();
   int    err_before;
   int    cycles;
   addr_t pc;
   err_before = errors;
   issue_branch(32'h200);
   pc = 32'h200;
   repeat (2) begin
      pop_expect(pc);
      pc = pc + 32'd4;
   end
   // Wait for the prefetch of the next line to be in flight in the cache.
   cycles = 0;
   while (!(fetch_top_inst.icache_inst.in_refill && fetch_top_inst.ifq_inst.outstanding) &&
          cycles < 100) begin
      @(posedge clk);
      #1;
      cycles++;
   end
   if (cycles >= 100) begin
      $display("no refill became outstanding after the branch to 200");
      errors++;
   end
   issue_branch(32'h0B8);
   pc = 32'h0B8;
   repeat (12) begin
      pop_expect(pc);
      pc = pc + 32'd4;
   end
   report_test("branch_during_refill", err_before);
endtask

// Line 11 was fetched by the previous test and is still in the cache.
// With the queue full the cache is idle when the branch arrives.
task automatic branch_to_cached();
   int    err_before;
   addr_t pc;
   err_before = errors;
   wait_queue_full();
   issue_branch(32'h0B4);
   // A hit shows the first word two cycles after the branch, through the bypass.
   @(negedge clk);
   check_val("dispatch_empty", 1, dispatch_empty);
   @(negedge clk);
   check_val("dispatch_empty", 0, dispatch_empty);
   @(posedge clk);
   #1;
   pc = 32'h0B4;
   repeat (10) begin
      pop_expect(pc);
      pc = pc + 32'd4;
   end
   report_test("branch_to_cached", err_before);
endtask

`endif

//--- verif/fetch_tb.sv
`timescale 1ns/1ps
`include "fetch_cfg.svh"

module fetch_tb;
   import fetch_pkg::*;

   localparam int CLK_HALF = 4;
   localparam int POP_LIMIT = 200;
   localparam logic [31:0] SEED = 32'h7348_7046;

   // The full run is around 600 cycles of 8 ns, so this leaves a wide margin.
   localparam time WATCHDOG_NS = 20000;

   logic  clk = 1'b0;
   logic  rst;
   load_t load;
   logic  dispatch_ren;
   logic  branch_valid;
   addr_t branch_addr;
   inst_t dispatch_inst;
   addr_t dispatch_pc_plus4;
   logic  dispatch_empty;

   int errors = 0;
   int checks = 0;

   always #(CLK_HALF) clk = ~clk;

   fetch_top fetch_top_inst (
      .clk               (clk),
      .rst               (rst),
      .load              (load),
      .dispatch_ren      (dispatch_ren),
      .branch_valid      (branch_valid),
      .branch_addr       (branch_addr),
      .dispatch_inst     (dispatch_inst),
      .dispatch_pc_plus4 (dispatch_pc_plus4),
      .dispatch_empty    (dispatch_empty)
   );

   // Program image. Each word holds the low half of its own address, once as is
   // and once inverted, so a wrong word or a wrong line shows up at once.
   function automatic inst_t model_inst(input addr_t a);
      return {a[15:0], ~a[15:0]};
   endfunction

   function automatic line_t model_line(input int idx);
      line_t l;
      for (int k = 0; k < 4; k++) begin
         l[32*k +: 32] = model_inst(addr_t'(idx * 16 + 4 * k));
      end
      return l;
   endfunction

   task automatic check_val(input string name, input logic [31:0] exp, input logic [31:0] act);
      checks++;
      if (exp !== act) begin
         $display("error at %t: %s expected %h actual %h", $time, name, exp, act);
         errors++;
      end
   endtask

   task automatic report_test(input string name, input int err_before);
      $display("%s finished with %0d errors", name, errors - err_before);
   endtask

   // Holds dispatch_ren high until an instruction is shown, checks it, and lets
   // it pop at the next edge. Entered and left 1 ns after a rising edge.
   task automatic pop_expect(input addr_t pc);
      int wait_cycles;
      wait_cycles = 0;
      dispatch_ren = 1'b1;
      @(negedge clk);
      while (dispatch_empty && wait_cycles < POP_LIMIT) begin
         @(negedge clk);
         wait_cycles++;
      end
      if (dispatch_empty) begin
         $display("no instruction for pc %h arrived within %0d cycles", pc, POP_LIMIT);
         errors++;
      end else begin
         check_val("dispatch_inst", model_inst(pc), dispatch_inst);
         check_val("dispatch_pc_plus4", pc + 32'd4, dispatch_pc_plus4);
      end
      @(posedge clk);
      #1;
      dispatch_ren = 1'b0;
   endtask

   task automatic issue_branch(input addr_t target);
      branch_valid = 1'b1;
      branch_addr  = target;
      @(posedge clk);
      #1;
      branch_valid = 1'b0;
   endtask

   // Waits until the fetch queue holds all its lines. Entered and left 1 ns
   // after a rising edge.
   task automatic wait_queue_full();
      int cycles;
      cycles = 0;
      while (fetch_top_inst.ifq_inst.q_count != `FETCH_Q_LINES && cycles < POP_LIMIT) begin
         @(posedge clk);
         #1;
         cycles++;
      end
      if (fetch_top_inst.ifq_inst.q_count != `FETCH_Q_LINES) begin
         $display("fetch queue did not fill within %0d cycles", POP_LIMIT);
         errors++;
      end
   endtask

   `include "fetch_tests.svh"

   initial begin
      #(WATCHDOG_NS);
      $display("watchdog expired after %0t before the tests finished", $time);
      $display("TB FAILED");
      $finish;
   end

   initial begin
      $timeformat(-9, 0, " ns", 0);
      void'($urandom(SEED));
      rst          = 1'b1;
      load         = '0;
      dispatch_ren = 1'b0;
      branch_valid = 1'b0;
      branch_addr  = '0;
      repeat (4) @(posedge clk);
      #1;
      rst = 1'b0;

      idle_before_branch();
      load_program();
      sequential_fetch();
      backpressure_fetch();
      branch_during_refill();
      branch_to_cached();

      $display("checks %0d, errors %0d", checks, errors);
      if (errors == 0) begin
         $display("TB PASSED");
      end else begin
         $display("TB FAILED");
      end
      $finish;
   end

endmodule

//--- verilog.f
+incdir+hw
+incdir+verif
hw/fetch_pkg.sv
hw/line_mem.sv
hw/icache.sv
hw/ifq.sv
hw/fetch_top.sv
verif/fetch_tb.sv
